/* aluPkg.sv */
// ALU shared definitions
`default_nettype none

package aluPkg;

    // Operand and result width
    localparam int DataWidth = 32;

    // Command encoding of the ALU
    typedef enum logic [2:0] {
        CmdAdd  = 3'd0,
        CmdSub  = 3'd1,
        CmdXor  = 3'd2,
        CmdSlt  = 3'd3,
        CmdAnd  = 3'd4,
        CmdNand = 3'd5,
        CmdNor  = 3'd6,
        CmdOr   = 3'd7
    } aluCmdE;

    // Result source for the output mux
    typedef enum logic [2:0] {
        SelArith = 3'd0,
        SelXor   = 3'd1,
        SelSlt   = 3'd2,
        SelNand  = 3'd3,
        SelNor   = 3'd4
    } aluSelE;

    // One result record, 35 bits
    typedef struct packed {
        logic [DataWidth-1:0] result;
        logic                 carryout;
        logic                 zero;
        logic                 overflow;
    } aluResultT;

endpackage

`default_nettype wire

/* aluControl.sv */
// ALU control lookup
`timescale 1ns/1ps
`default_nettype none

module aluControl import aluPkg::*; (
    input  aluCmdE command,
    output aluSelE select,
    output logic   invertB,
    output logic   invertOut,
    output logic   carryIn,
    output logic   isArith
);

    always_comb begin
        select    = SelArith;
        invertB   = 1'b0;
        invertOut = 1'b0;
        carryIn   = 1'b0;
        isArith   = 1'b0;
        case (command)
            CmdAdd: begin
                isArith = 1'b1;
            end
            CmdSub: begin
                invertB = 1'b1;
                carryIn = 1'b1;
                isArith = 1'b1;
            end
            CmdXor: select = SelXor;
            // SLT runs a subtraction but keeps its flags off
            CmdSlt: begin
                select  = SelSlt;
                invertB = 1'b1;
                carryIn = 1'b1;
            end
            CmdAnd: begin
                select    = SelNand;
                invertOut = 1'b1;
            end
            CmdNand: select = SelNand;
            CmdNor:  select = SelNor;
            CmdOr: begin
                select    = SelNor;
                invertOut = 1'b1;
            end
            default: select = SelArith;
        endcase
    end

endmodule

`default_nettype wire

/* arithUnit.sv */
// Adder, subtractor and set-less-than
`timescale 1ns/1ps
`default_nettype none

module arithUnit import aluPkg::*; (
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    input  logic                 invertB,
    input  logic                 carryIn,
    output logic [DataWidth-1:0] sum,
    output logic                 carryout,
    output logic                 overflow,
    output logic [DataWidth-1:0] sltResult
);

    logic [DataWidth-1:0] bIn;
    logic                 carryIntoTop;

    // Two's complement subtract is A + ~B + 1
    assign bIn = operandB ^ {DataWidth{invertB}};

    // Lower bits first so the carry into the sign bit is visible
    assign {carryIntoTop, sum[DataWidth-2:0]} = {1'b0, operandA[DataWidth-2:0]}
                                              + {1'b0, bIn[DataWidth-2:0]}
                                              + {{(DataWidth-1){1'b0}}, carryIn};

    assign {carryout, sum[DataWidth-1]} = {1'b0, operandA[DataWidth-1]}
                                        + {1'b0, bIn[DataWidth-1]}
                                        + {1'b0, carryIntoTop};

    assign overflow = carryIntoTop ^ carryout;

    // A < B when the difference is negative, corrected by overflow
    assign sltResult = {{(DataWidth-1){1'b0}}, sum[DataWidth-1] ^ overflow};

endmodule

`default_nettype wire

/* logicUnit.sv */
// Bitwise logic unit
`timescale 1ns/1ps
`default_nettype none

module logicUnit import aluPkg::*; (
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    input  logic                 invertOut,
    output logic [DataWidth-1:0] xorResult,
    output logic [DataWidth-1:0] nandResult,
    output logic [DataWidth-1:0] norResult
);

    logic [DataWidth-1:0] invMask;

    assign invMask = {DataWidth{invertOut}};

    assign xorResult = operandA ^ operandB;

    // Inverted NAND gives AND, inverted NOR gives OR
    assign nandResult = ~(operandA & operandB) ^ invMask;
    assign norResult  = ~(operandA | operandB) ^ invMask;

endmodule

`default_nettype wire

/* aluCore.sv */
// Combinational ALU core
`timescale 1ns/1ps
`default_nettype none

module aluCore import aluPkg::*; (
    input  aluCmdE               command,
    input  logic [DataWidth-1:0] operandA,
    input  logic [DataWidth-1:0] operandB,
    output aluResultT            record
);

    aluSelE               select;
    logic                 invertB;
    logic                 invertOut;
    logic                 carryIn;
    logic                 isArith;
    logic [DataWidth-1:0] sum;
    logic                 carryout;
    logic                 overflow;
    logic [DataWidth-1:0] sltResult;
    logic [DataWidth-1:0] xorResult;
    logic [DataWidth-1:0] nandResult;
    logic [DataWidth-1:0] norResult;
    logic [DataWidth-1:0] selected;

    aluControl uControl (
        .command  (command),
        .select   (select),
        .invertB  (invertB),
        .invertOut(invertOut),
        .carryIn  (carryIn),
        .isArith  (isArith)
    );

    arithUnit uArith (
        .operandA (operandA),
        .operandB (operandB),
        .invertB  (invertB),
        .carryIn  (carryIn),
        .sum      (sum),
        .carryout (carryout),
        .overflow (overflow),
        .sltResult(sltResult)
    );

    logicUnit uLogic (
        .operandA  (operandA),
        .operandB  (operandB),
        .invertOut (invertOut),
        .xorResult (xorResult),
        .nandResult(nandResult),
        .norResult (norResult)
    );

    always_comb begin
        case (select)
            SelXor:  selected = xorResult;
            SelSlt:  selected = sltResult;
            SelNand: selected = nandResult;
            SelNor:  selected = norResult;
            default: selected = sum;
        endcase
    end

    // Flags from the adder only count for ADD and SUB
    assign record.result   = selected;
    assign record.carryout = carryout & isArith;
    assign record.overflow = overflow & isArith;
    assign record.zero     = (selected == '0);

endmodule

`default_nettype wire

/* resultQueue.sv */
// Result record FIFO
`timescale 1ns/1ps
`default_nettype none

module resultQueue #(
    parameter int  QueueDepth = 4,
    parameter type PayloadT   = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    push,
    input  PayloadT pushData,
    input  logic    pop,
    output PayloadT popData,
    output logic    notEmpty
);

    localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountWidth = $clog2(QueueDepth + 1);
    localparam logic [PtrWidth-1:0] LastSlot = PtrWidth'(QueueDepth - 1);

    PayloadT               mem [QueueDepth];
    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign popData  = mem[rdPtr];
    assign notEmpty = (count != '0);

endmodule

`default_nettype wire

/* resultSender.sv */
// Output register with downstream credits
`timescale 1ns/1ps
`default_nettype none

module resultSender import aluPkg::*; #(
    parameter int OutCredits = 2
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  aluResultT            queueData,
    input  logic                 notEmpty,
    input  logic                 outCredit,
    output logic                 pop,
    output logic                 outValid,
    output logic [DataWidth-1:0] outResult,
    output logic                 outCarryout,
    output logic                 outZero,
    output logic                 outOverflow
);

    localparam int CountWidth = $clog2(OutCredits + 1);

    logic [CountWidth-1:0] creditCount;

    assign pop = notEmpty && (creditCount != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            creditCount <= CountWidth'(OutCredits);
            outValid    <= 1'b0;
        end else begin
            outValid <= pop;
            case ({pop, outCredit})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    // Output payload register
    always_ff @(posedge clk) begin
        if (pop) begin
            outResult   <= queueData.result;
            outCarryout <= queueData.carryout;
            outZero     <= queueData.zero;
            outOverflow <= queueData.overflow;
        end
    end

endmodule

`default_nettype wire

/* aluTop.sv */
// Credit-flow ALU top level
`timescale 1ns/1ps
`default_nettype none

module aluTop import aluPkg::*; #(
    parameter int QueueDepth = 4,
    parameter int OutCredits = 2
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  aluCmdE               inCommand,
    input  logic [DataWidth-1:0] inOperandA,
    input  logic [DataWidth-1:0] inOperandB,
    output logic                 inCredit,
    input  logic                 outCredit,
    output logic                 outValid,
    output logic [DataWidth-1:0] outResult,
    output logic                 outCarryout,
    output logic                 outZero,
    output logic                 outOverflow
);

    logic                 opValid;
    aluCmdE               opCommand;
    logic [DataWidth-1:0] opA;
    logic [DataWidth-1:0] opB;
    aluResultT            coreRecord;
    aluResultT            queueData;
    logic                 notEmpty;
    logic                 pop;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            opValid <= 1'b0;
        end else begin
            opValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            opCommand <= inCommand;
            opA       <= inOperandA;
            opB       <= inOperandB;
        end
    end

    aluCore uCore (
        .command (opCommand),
        .operandA(opA),
        .operandB(opB),
        .record  (coreRecord)
    );

    resultQueue #(
        .QueueDepth(QueueDepth),
        .PayloadT  (aluResultT)
    ) uQueue (
        .clk     (clk),
        .rstN    (rstN),
        .push    (opValid),
        .pushData(coreRecord),
        .pop     (pop),
        .popData (queueData),
        .notEmpty(notEmpty)
    );

    resultSender #(
        .OutCredits(OutCredits)
    ) uSender (
        .clk        (clk),
        .rstN       (rstN),
        .queueData  (queueData),
        .notEmpty   (notEmpty),
        .outCredit  (outCredit),
        .pop        (pop),
        .outValid   (outValid),
        .outResult  (outResult),
        .outCarryout(outCarryout),
        .outZero    (outZero),
        .outOverflow(outOverflow)
    );

    // Each record leaving the queue frees one upstream slot
    assign inCredit = pop;

endmodule

`default_nettype wire

/* tbAlu.sv */
// ALU stream testbench
`timescale 1ns/1ps
`default_nettype none

module tbAlu import aluPkg::*; ();

    localparam int NumTests   = 21;
    localparam int QueueDepth = 4;
    localparam int OutCredits = 3;
    localparam int HoldCycles = 30;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 inValid;
    aluCmdE               inCommand;
    logic [DataWidth-1:0] inOperandA;
    logic [DataWidth-1:0] inOperandB;
    logic                 inCredit;
    logic                 outCredit;
    logic                 outValid;
    logic [DataWidth-1:0] outResult;
    logic                 outCarryout;
    logic                 outZero;
    logic                 outOverflow;

    // Test table
    string                tName   [NumTests];
    aluCmdE               tCmd    [NumTests];
    logic [DataWidth-1:0] tA      [NumTests];
    logic [DataWidth-1:0] tB      [NumTests];
    logic [DataWidth-1:0] tResult [NumTests];
    logic                 tCarry  [NumTests];
    logic                 tZero   [NumTests];
    logic                 tOvf    [NumTests];

    int seed;
    int numEntries;
    int sentCount;
    int rxCount;
    int inCreditCount;
    int outValidCount;
    int passCount;
    int failCount;
    int errors;
    int cycle;
    int delay;
    int due;
    int pending[$];

    aluTop #(
        .QueueDepth(QueueDepth),
        .OutCredits(OutCredits)
    ) DUT (
        .clk        (clk),
        .rstN       (rstN),
        .inValid    (inValid),
        .inCommand  (inCommand),
        .inOperandA (inOperandA),
        .inOperandB (inOperandB),
        .inCredit   (inCredit),
        .outCredit  (outCredit),
        .outValid   (outValid),
        .outResult  (outResult),
        .outCarryout(outCarryout),
        .outZero    (outZero),
        .outOverflow(outOverflow)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic addEntry(input string n, input aluCmdE c, input logic [DataWidth-1:0] a,
                            input logic [DataWidth-1:0] b, input logic [DataWidth-1:0] r,
                            input logic co, input logic z, input logic v);
        tName[numEntries]   = n;
        tCmd[numEntries]    = c;
        tA[numEntries]      = a;
        tB[numEntries]      = b;
        tResult[numEntries] = r;
        tCarry[numEntries]  = co;
        tZero[numEntries]   = z;
        tOvf[numEntries]    = v;
        numEntries          = numEntries + 1;
    endtask

    task automatic fillTable();
        // All four carry/overflow pairs for ADD, then for SUB
        addEntry("add_plain", CmdAdd, 32'h00000001, 32'h00000002, 32'h00000003, 0, 0, 0);
        addEntry("add_carry_ovf", CmdAdd, 32'h80000000, 32'h80000000, 32'h00000000, 1, 1, 1);
        addEntry("add_ovf", CmdAdd, 32'h7FFFFFFF, 32'h00000001, 32'h80000000, 0, 0, 1);
        addEntry("add_carry", CmdAdd, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 1, 1, 0);
        addEntry("sub_equal", CmdSub, 32'h12345678, 32'h12345678, 32'h00000000, 1, 1, 0);
        addEntry("sub_ovf", CmdSub, 32'h40000000, 32'h80000001, 32'hBFFFFFFF, 0, 0, 1);
        addEntry("sub_borrow", CmdSub, 32'h00000001, 32'h00000002, 32'hFFFFFFFF, 0, 0, 0);
        addEntry("sub_carry_ovf", CmdSub, 32'h80000000, 32'h00000001, 32'h7FFFFFFF, 1, 0, 1);
        addEntry("slt_equal", CmdSlt, 32'h00000005, 32'h00000005, 32'h00000000, 0, 1, 0);
        addEntry("slt_neg_ovf", CmdSlt, 32'h80000000, 32'h00000001, 32'h00000001, 0, 0, 0);
        addEntry("slt_pos_ovf", CmdSlt, 32'h7FFFFFFF, 32'h80000000, 32'h00000000, 0, 1, 0);
        addEntry("slt_less", CmdSlt, 32'hFFFFFFFF, 32'h00000002, 32'h00000001, 0, 0, 0);
        addEntry("xor_mix", CmdXor, 32'hF0F0F0F0, 32'hFF00FF00, 32'h0FF00FF0, 0, 0, 0);
        addEntry("xor_zero", CmdXor, 32'hA5A5A5A5, 32'hA5A5A5A5, 32'h00000000, 0, 1, 0);
        addEntry("and_zero", CmdAnd, 32'hAAAAAAAA, 32'h55555555, 32'h00000000, 0, 1, 0);
        addEntry("and_mix", CmdAnd, 32'hFFFF0000, 32'h0F0F0F0F, 32'h0F0F0000, 0, 0, 0);
        addEntry("nand_mix", CmdNand, 32'hFFFF0000, 32'h0F0F0F0F, 32'hF0F0FFFF, 0, 0, 0);
        addEntry("nor_mix", CmdNor, 32'hF0F00000, 32'h0000000F, 32'h0F0FFFF0, 0, 0, 0);
        addEntry("or_mix", CmdOr, 32'h12340000, 32'h00005678, 32'h12345678, 0, 0, 0);
        addEntry("nor_zero", CmdNor, 32'hFFFFFFFF, 32'h00000000, 32'h00000000, 0, 1, 0);
        addEntry("or_sign", CmdOr, 32'h80000000, 32'h80000000, 32'h80000000, 0, 0, 0);
    endtask

    task automatic checkRecord(input int idx);
        if (outResult !== tResult[idx] || outCarryout !== tCarry[idx]
                || outZero !== tZero[idx] || outOverflow !== tOvf[idx]) begin
            $display("mismatch %s: expected %h c%0b z%0b v%0b, actual %h c%0b z%0b v%0b",
                     tName[idx], tResult[idx], tCarry[idx], tZero[idx], tOvf[idx],
                     outResult, outCarryout, outZero, outOverflow);
            failCount = failCount + 1;
        end else begin
            $display("ok %s", tName[idx]);
            passCount = passCount + 1;
        end
    endtask

    initial begin
        seed          = 32'h1549;
        numEntries    = 0;
        sentCount     = 0;
        rxCount       = 0;
        inCreditCount = 0;
        outValidCount = 0;
        passCount     = 0;
        failCount     = 0;
        errors        = 0;
        cycle         = 0;
        rstN          = 1'b0;
        inValid       = 1'b0;
        inCommand     = CmdAdd;
        inOperandA    = '0;
        inOperandB    = '0;
        outCredit     = 1'b0;
        fillTable();
        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;
        wait (rxCount == NumTests);
        repeat (20) @(posedge clk);
        if (sentCount != NumTests || inCreditCount != sentCount) begin
            $display("Sent %0d operations but saw %0d inCredit pulses", sentCount, inCreditCount);
            errors = errors + 1;
        end
        $display("Tests: %0d passed, %0d failed, %0d other errors", passCount, failCount, errors);
        if (failCount == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Source spends one credit per operation
    initial begin : source
        int idx;
        idx = 0;
        wait (rstN === 1'b1);
        while (idx < NumTests) begin
            @(posedge clk);
            #1;
            if (QueueDepth + inCreditCount - sentCount > 0) begin
                inValid    = 1'b1;
                inCommand  = tCmd[idx];
                inOperandA = tA[idx];
                inOperandB = tB[idx];
                sentCount  = sentCount + 1;
                idx        = idx + 1;
            end else begin
                inValid = 1'b0;
            end
        end
        @(posedge clk);
        #1 inValid = 1'b0;
    end

    // Sink returns one credit per record, none before HoldCycles
    initial begin : creditReturn
        wait (rstN === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (pending.size() > 0 && pending[0] <= cycle) begin
                void'(pending.pop_front());
                outCredit = 1'b1;
            end else begin
                outCredit = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (rstN !== 1'b1 || cycle < 2) begin
            if (outValid !== 1'b0 || inCredit !== 1'b0) begin
                $display("outValid or inCredit was not low during or right after reset");
                errors = errors + 1;
            end
        end
        if (rstN === 1'b1) begin
            if (inCredit === 1'b1) begin
                inCreditCount = inCreditCount + 1;
            end
            if (outValid === 1'b1) begin
                outValidCount = outValidCount + 1;
                if (rxCount >= NumTests) begin
                    $display("Unexpected extra output record after all tests");
                    errors = errors + 1;
                end else begin
                    checkRecord(rxCount);
                    rxCount = rxCount + 1;
                end
                delay = {$random(seed)} % 8;
                due   = cycle + delay;
                if (due < HoldCycles) begin
                    due = HoldCycles;
                end
                pending.push_back(due);
            end
            // A pop shows up as outValid one cycle later
            if (inCreditCount - outValidCount != int'(inCredit)) begin
                $display("inCredit pulses do not match records that left the queue");
                errors = errors + 1;
            end
            if (cycle < HoldCycles && (outValidCount > OutCredits
                                       || inCreditCount > OutCredits)) begin
                $display("More than %0d records sent while credits were withheld", OutCredits);
                errors = errors + 1;
            end
            cycle = cycle + 1;
        end
    end

    initial begin : watchdog
        repeat (16 + NumTests * 40) @(posedge clk);
        $display("Timeout with %0d of %0d results received", rxCount, NumTests);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
aluPkg.sv
aluControl.sv
arithUnit.sv
logicUnit.sv
aluCore.sv
resultQueue.sv
resultSender.sv
aluTop.sv
tbAlu.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tbAlu -f compile.f -o tbAlu
simOutput=$(./obj_dir/tbAlu)
echo "$simOutput"

if echo "$simOutput" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
